/* src/reorderQueue_consts.svh */
`ifndef REORDERQUEUE_CONSTS_SVH
`define REORDERQUEUE_CONSTS_SVH

// --------------------------------------------------
// Payload geometry
// --------------------------------------------------
`define RQ_DATA_WIDTH 128
`define RQ_LANES 4
`define RQ_LANE_SEL_WIDTH 2

// --------------------------------------------------
// Tag and address space
// --------------------------------------------------
`define RQ_TAG_WIDTH 5
`define RQ_NUM_TAGS 32
`define RQ_COUNT_WIDTH 8
// 32 word slots per lane for each tag
`define RQ_STRIDE_WIDTH 5
`define RQ_ADDR_WIDTH 10
`define RQ_PIPE_DEPTH 6

`endif

/* src/reorderQueuePkg.sv */
`include "reorderQueue_consts.svh"

package reorderQueuePkg;

    // Tag of an outstanding request
    typedef logic [`RQ_TAG_WIDTH-1:0] tagType;

    // One bit per tag
    typedef logic [`RQ_NUM_TAGS-1:0] tagMapType;

    // Running word count of a packet
    typedef logic [`RQ_COUNT_WIDTH-1:0] countType;

    // One bit per 32-bit lane
    typedef logic [`RQ_LANES-1:0] laneMaskType;
    typedef logic [`RQ_LANE_SEL_WIDTH-1:0] laneSelType;

    // Fill position inside one lane
    typedef logic [`RQ_STRIDE_WIDTH-1:0] strideType;

    // Stored word address, tag in the upper bits
    typedef logic [`RQ_ADDR_WIDTH-1:0] addrType;

    typedef logic [`RQ_DATA_WIDTH-1:0] dataType;

endpackage

/* src/beatIf.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

// One counted beat, present whenever beatValid is high
interface beatIf;
    import reorderQueuePkg::*;

    logic        beatValid;
    tagType      beatTag;
    // Enables already rotated to the tag's fill lanes
    laneMaskType laneEn;
    // Old count modulo lanes
    laneSelType  rotate;
    // Running count including this beat
    countType    words;
    logic        done;
    logic        err;
    // Payload shifted down by the start offset
    dataType     data;

    // --------------------------------------------------
    // Views
    // --------------------------------------------------
    modport source (
        output beatValid, beatTag, laneEn, rotate, words, done, err, data
    );

    // Lane slots only need the tag and their enable bit
    modport lane (
        input beatValid, beatTag, laneEn
    );

    modport sink (
        input beatValid, beatTag, rotate, words, done, err, data
    );

endinterface

/* src/wordCounter.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

module wordCounter (
    input  logic                         CLK,
    input  logic                         RST,
    input  logic                         valid,
    input  reorderQueuePkg::dataType     data,
    input  reorderQueuePkg::laneMaskType dataEn,
    input  logic                         startFlag,
    input  reorderQueuePkg::laneSelType  startOffset,
    input  logic                         done,
    input  logic                         err,
    input  reorderQueuePkg::tagType      tag,
    input  reorderQueuePkg::tagMapType   tagClear,
    beatIf.source                        beat,
    output reorderQueuePkg::tagMapType   tagFinish
);
    import reorderQueuePkg::*;

    // Stage 0, raw input capture
    logic        valid0;
    tagType      tag0;
    dataType     data0;
    laneMaskType en0;
    logic        startFlag0;
    laneSelType  offset0;
    logic        done0;
    logic        err0;

    // Start alignment
    laneSelType  shiftDown;
    laneMaskType enAligned;
    dataType     dataAligned;
    countType    beatWords;

    // Stage 1, aligned beat and count RAM read
    logic        valid1;
    tagType      tag1;
    laneMaskType en1;
    dataType     data1;
    countType    cnt1;
    logic        done1;
    logic        err1;
    countType    ramQ;
    logic        tagLive1;
    logic        useCurr;
    logic        usePrev;

    // Stage 2, new count
    logic        valid2;
    tagType      tag2;
    laneMaskType en2;
    dataType     data2;
    logic        done2;
    logic        err2;
    countType    baseCount;
    countType    count;
    countType    prevCount;
    laneSelType  oldLane;
    logic [2*`RQ_LANES-1:0] enRot;

    // Per-tag state
    countType    countRam [`RQ_NUM_TAGS];
    tagMapType   tagUsed;

    // Finish flag follows the beat to the output edge
    logic [`RQ_PIPE_DEPTH-4:0] finValid;
    tagType      finTag [`RQ_PIPE_DEPTH-3];

    // --------------------------------------------------
    // Start offset alignment and word count
    // --------------------------------------------------
    always_comb begin
        shiftDown = startFlag0 ? offset0 : '0;
        enAligned = en0 >> shiftDown;
        dataAligned = data0 >> {shiftDown, 5'd0};
        beatWords = '0;
        for (int i = 0; i < `RQ_LANES; i++) begin
            beatWords = beatWords + countType'(enAligned[i]);
        end
    end

    // Forward over the read-to-write gap, else RAM value unless tag was cleared
    always_comb begin
        if (useCurr) begin
            baseCount = count;
        end else if (usePrev) begin
            baseCount = prevCount;
        end else begin
            baseCount = tagLive1 ? ramQ : '0;
        end
        // Fill lanes start where the tag left off
        enRot = {en2, en2} << oldLane;
    end

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            useCurr <= 1'b0;
            usePrev <= 1'b0;
            tagUsed <= '0;
            beat.beatValid <= 1'b0;
            beat.laneEn <= '0;
            finValid <= '0;
            tagFinish <= '0;
        end else begin
            valid0 <= valid;
            valid1 <= valid0;
            valid2 <= valid1;
            // Same tag one or two beats ahead
            useCurr <= valid1 && (tag1 == tag0);
            usePrev <= valid2 && (tag2 == tag0);
            // Clear wins over a new beat of the same tag
            tagUsed <= (tagUsed | (valid0 ? tagMapType'(1) << tag0 : '0)) & ~tagClear;
            beat.beatValid <= valid2;
            beat.laneEn <= valid2 ? enRot[2*`RQ_LANES-1:`RQ_LANES] : '0;
            finValid <= {finValid[`RQ_PIPE_DEPTH-5:0], valid2 & (done2 | err2)};
            tagFinish <= finValid[`RQ_PIPE_DEPTH-4] ?
                         tagMapType'(1) << finTag[`RQ_PIPE_DEPTH-4] : '0;
        end
    end

    // --------------------------------------------------
    // Beat payload pipeline
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        tag0 <= tag;
        data0 <= data;
        en0 <= dataEn;
        startFlag0 <= startFlag;
        offset0 <= startOffset;
        done0 <= done;
        err0 <= err;

        tag1 <= tag0;
        en1 <= enAligned;
        data1 <= dataAligned;
        cnt1 <= beatWords;
        done1 <= done0;
        err1 <= err0;
        ramQ <= countRam[tag0];
        tagLive1 <= tagUsed[tag0];

        tag2 <= tag1;
        en2 <= en1;
        data2 <= data1;
        done2 <= done1;
        err2 <= err1;
        count <= baseCount + cnt1;
        prevCount <= count;
        oldLane <= baseCount[`RQ_LANE_SEL_WIDTH-1:0];

        beat.beatTag <= tag2;
        beat.rotate <= oldLane;
        beat.words <= count;
        beat.done <= done2;
        beat.err <= err2;
        beat.data <= data2;

        finTag[0] <= tag2;
        for (int k = 1; k < `RQ_PIPE_DEPTH-3; k++) begin
            finTag[k] <= finTag[k-1];
        end
    end

    // Count RAM, written one edge after the count forms
    always_ff @(posedge CLK) begin
        if (valid2) begin
            countRam[tag2] <= count;
        end
    end

endmodule

/* src/laneSlot.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

module laneSlot (
    input  logic                        CLK,
    input  logic                        RST,
    input  reorderQueuePkg::tagMapType  tagClear,
    beatIf.lane                         beat,
    input  reorderQueuePkg::laneSelType laneIdx,
    output reorderQueuePkg::addrType    addr,
    output logic                        en
);
    import reorderQueuePkg::*;

    // Stage 1, position RAM read
    logic      valid1;
    tagType    tag1;
    logic      en1;
    strideType posQ;
    logic      posLive1;
    logic      useCurr;
    logic      usePrev;

    // Stage 2, position update
    logic      valid2;
    tagType    tag2;
    logic      en2;
    strideType basePos;
    strideType pos;
    strideType prevPos;
    strideType oldPos;

    // Fill position of each tag in this lane
    strideType posRam [`RQ_NUM_TAGS];
    tagMapType posUsed;

    // --------------------------------------------------
    // Forwarding
    // --------------------------------------------------
    always_comb begin
        if (useCurr) begin
            basePos = pos;
        end else if (usePrev) begin
            basePos = prevPos;
        end else begin
            // Cleared or never used tag starts at slot 0
            basePos = posLive1 ? posQ : '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            useCurr <= 1'b0;
            usePrev <= 1'b0;
            posUsed <= '0;
            en <= 1'b0;
        end else begin
            valid1 <= beat.beatValid;
            valid2 <= valid1;
            useCurr <= valid1 && (tag1 == beat.beatTag);
            usePrev <= valid2 && (tag2 == beat.beatTag);
            posUsed <= (posUsed | (beat.beatValid ? tagMapType'(1) << beat.beatTag : '0))
                       & ~tagClear;
            en <= valid2 & en2;
        end
    end

    // --------------------------------------------------
    // Read, forward and add, base plus position
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        tag1 <= beat.beatTag;
        en1 <= beat.laneEn[laneIdx];
        posQ <= posRam[beat.beatTag];
        posLive1 <= posUsed[beat.beatTag];

        tag2 <= tag1;
        en2 <= en1;
        oldPos <= basePos;
        // Advance only when a word lands in this lane
        pos <= basePos + strideType'(en1);
        prevPos <= pos;

        // Tag region is 32 words deep
        addr <= {tag2, {`RQ_STRIDE_WIDTH{1'b0}}} + addrType'(oldPos);
    end

    always_ff @(posedge CLK) begin
        if (valid2) begin
            posRam[tag2] <= pos;
        end
    end

endmodule

/* src/payloadAligner.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

module payloadAligner (
    input  logic                     CLK,
    input  logic                     RST,
    beatIf.sink                      beat,
    output reorderQueuePkg::dataType storedData,
    output logic                     pktValid,
    output logic                     pktDone,
    output logic                     pktErr,
    output logic                     pktWordsLte1,
    output logic                     pktWordsLte2,
    output reorderQueuePkg::tagType  pktTag,
    output reorderQueuePkg::countType pktWords
);
    import reorderQueuePkg::*;

    // Stage 1
    logic       valid1;
    tagType     tag1;
    countType   words1;
    logic       done1;
    logic       err1;
    dataType    data1;
    laneSelType rot1;

    // Stage 2
    logic       valid2;
    tagType     tag2;
    countType   words2;
    logic       done2;
    logic       err2;
    dataType    data2;
    logic       lte1;
    logic       lte2;

    logic [2*`RQ_DATA_WIDTH-1:0] dataDup;

    // --------------------------------------------------
    // Word rotation up by the tag's old count
    // --------------------------------------------------
    always_comb begin
        dataDup = {data1, data1} << {rot1, 5'd0};
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            pktValid <= 1'b0;
        end else begin
            valid1 <= beat.beatValid;
            valid2 <= valid1;
            pktValid <= valid2;
        end
    end

    always_ff @(posedge CLK) begin
        tag1 <= beat.beatTag;
        words1 <= beat.words;
        done1 <= beat.done;
        err1 <= beat.err;
        data1 <= beat.data;
        rot1 <= beat.rotate;

        tag2 <= tag1;
        words2 <= words1;
        done2 <= done1;
        err2 <= err1;
        data2 <= dataDup[2*`RQ_DATA_WIDTH-1:`RQ_DATA_WIDTH];
        // Packet fits in one or two beats
        lte1 <= words1 <= countType'(`RQ_LANES);
        lte2 <= words1 <= countType'(2*`RQ_LANES);

        pktTag <= tag2;
        pktWords <= words2;
        pktDone <= done2;
        pktErr <= err2;
        pktWordsLte1 <= lte1;
        pktWordsLte2 <= lte2;
        storedData <= data2;
    end

endmodule

/* src/reorderQueueInput.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

module reorderQueueInput (
    input  logic                                      CLK,
    input  logic                                      RST,
    // Incoming beat
    input  logic                                      valid,
    input  reorderQueuePkg::dataType                  data,
    input  reorderQueuePkg::laneMaskType              dataEn,
    input  logic                                      startFlag,
    input  reorderQueuePkg::laneSelType               startOffset,
    input  logic                                      done,
    input  logic                                      err,
    input  reorderQueuePkg::tagType                   tag,
    // Tag bookkeeping
    output reorderQueuePkg::tagMapType                tagFinish,
    input  reorderQueuePkg::tagMapType                tagClear,
    // RAM write side
    output reorderQueuePkg::addrType [`RQ_LANES-1:0]  storedAddr,
    output reorderQueuePkg::dataType                  storedData,
    output reorderQueuePkg::laneMaskType              storedEn,
    // Packet info, aligned with the RAM write
    output logic                                      pktValid,
    output reorderQueuePkg::tagType                   pktTag,
    output reorderQueuePkg::countType                 pktWords,
    output logic                                      pktWordsLte1,
    output logic                                      pktWordsLte2,
    output logic                                      pktDone,
    output logic                                      pktErr
);
    import reorderQueuePkg::*;

    beatIf beat ();

    // --------------------------------------------------
    // Count, align and rotate enables
    // --------------------------------------------------
    wordCounter uCounter (
        .CLK         (CLK),
        .RST         (RST),
        .valid       (valid),
        .data        (data),
        .dataEn      (dataEn),
        .startFlag   (startFlag),
        .startOffset (startOffset),
        .done        (done),
        .err         (err),
        .tag         (tag),
        .tagClear    (tagClear),
        .beat        (beat),
        .tagFinish   (tagFinish)
    );

    // One fill position tracker per RAM lane
    for (genvar i = 0; i < `RQ_LANES; i++) begin : gLane
        laneSlot uLane (
            .CLK      (CLK),
            .RST      (RST),
            .tagClear (tagClear),
            .beat     (beat),
            .laneIdx  (laneSelType'(i)),
            .addr     (storedAddr[i]),
            .en       (storedEn[i])
        );
    end

    payloadAligner uAligner (
        .CLK          (CLK),
        .RST          (RST),
        .beat         (beat),
        .storedData   (storedData),
        .pktValid     (pktValid),
        .pktDone      (pktDone),
        .pktErr       (pktErr),
        .pktWordsLte1 (pktWordsLte1),
        .pktWordsLte2 (pktWordsLte2),
        .pktTag       (pktTag),
        .pktWords     (pktWords)
    );

endmodule

/* verification/reorderQueueInputTb.sv */
`timescale 1ns/1ps
`include "reorderQueue_consts.svh"

module reorderQueueInputTb;
    import reorderQueuePkg::*;

    localparam int RESET_CYCLES = 5;
    // Directed tests and final drain stay below this
    localparam int DIRECTED_CYCLES = 64;
    localparam int RANDOM_BEATS = 300;
    localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_BEATS + 50;
    localparam int MAX_SLOTS = CYCLE_LIMIT + 8;

    // Expected outputs for one input cycle
    typedef struct packed {
        logic                    valid;
        tagType                  tag;
        countType                words;
        logic                    lte1;
        logic                    lte2;
        logic                    done;
        logic                    err;
        laneMaskType             en;
        addrType [`RQ_LANES-1:0] addr;
        dataType                 data;
        tagMapType               finish;
    } expectType;

    logic                    CLK;
    logic                    RST;
    logic                    valid;
    dataType                 data;
    laneMaskType             dataEn;
    logic                    startFlag;
    laneSelType              startOffset;
    logic                    done;
    logic                    err;
    tagType                  tag;
    tagMapType               tagFinish;
    tagMapType               tagClear;
    addrType [`RQ_LANES-1:0] storedAddr;
    dataType                 storedData;
    laneMaskType             storedEn;
    logic                    pktValid;
    tagType                  pktTag;
    countType                pktWords;
    logic                    pktWordsLte1;
    logic                    pktWordsLte2;
    logic                    pktDone;
    logic                    pktErr;

    // Reference state per tag
    countType    refCount [`RQ_NUM_TAGS];
    strideType   refPos [`RQ_NUM_TAGS][`RQ_LANES];
    expectType   expTable [MAX_SLOTS];
    logic [31:0] lcgState = 32'hb33f;
    int          edgeCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          beatsSent = 0;
    int          beatsSeen = 0;
    logic        checkOn = 1'b0;

    reorderQueueInput uut (
        .CLK(CLK), .RST(RST), .valid(valid), .data(data), .dataEn(dataEn),
        .startFlag(startFlag), .startOffset(startOffset), .done(done), .err(err),
        .tag(tag), .tagFinish(tagFinish), .tagClear(tagClear),
        .storedAddr(storedAddr), .storedData(storedData), .storedEn(storedEn),
        .pktValid(pktValid), .pktTag(pktTag), .pktWords(pktWords),
        .pktWordsLte1(pktWordsLte1), .pktWordsLte2(pktWordsLte2),
        .pktDone(pktDone), .pktErr(pktErr)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Cycle counter doubles as the watchdog
    always @(posedge CLK) begin
        edgeCount <= edgeCount + 1;
        if (edgeCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test never reached its end", edgeCount);
            $display("** FAIL **");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [31:0] randWord();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic dataType randData();
        dataType d;
        for (int i = 0; i < `RQ_LANES; i++) begin
            d[i*32 +: 32] = randWord();
        end
        return d;
    endfunction

    // Cleared tags restart at count 0 and slot 0 in every lane
    function automatic void clearModelTags(input tagMapType clr);
        for (int t = 0; t < `RQ_NUM_TAGS; t++) begin
            if (clr[t]) begin
                refCount[t] = '0;
                for (int l = 0; l < `RQ_LANES; l++) begin
                    refPos[t][l] = '0;
                end
            end
        end
    endfunction

    function automatic expectType predictBeat(input tagType t, input dataType d,
                                              input laneMaskType m, input logic sf,
                                              input laneSelType off, input logic dn,
                                              input logic er);
        expectType   e;
        laneSelType  shift;
        laneMaskType alignedEn;
        dataType     alignedData;
        countType    oldCount;
        countType    n;
        int          lane;
        e = '0;
        // Start beat drops the words below the offset
        shift = sf ? off : laneSelType'(0);
        alignedEn = m >> shift;
        alignedData = d >> (int'(shift) * 32);
        n = '0;
        for (int i = 0; i < `RQ_LANES; i++) begin
            n = n + countType'(alignedEn[i]);
        end
        oldCount = refCount[t];
        e.valid = 1'b1;
        e.tag = t;
        e.words = oldCount + n;
        e.lte1 = e.words <= countType'(4);
        e.lte2 = e.words <= countType'(8);
        e.done = dn;
        e.err = er;
        e.finish = (dn | er) ? tagMapType'(1) << t : '0;
        // Every lane reports its own slot, written or not
        for (int l = 0; l < `RQ_LANES; l++) begin
            e.addr[l] = addrType'(int'(t) * 32 + int'(refPos[t][l]));
        end
        // Word i lands in lane (old count + i) mod 4
        for (int i = 0; i < `RQ_LANES; i++) begin
            lane = (int'(oldCount) + i) % `RQ_LANES;
            e.en[lane] = alignedEn[i];
            e.data[lane*32 +: 32] = alignedData[i*32 +: 32];
        end
        for (int l = 0; l < `RQ_LANES; l++) begin
            if (e.en[l]) begin
                refPos[t][l] = refPos[t][l] + strideType'(1);
            end
        end
        refCount[t] = e.words;
        return e;
    endfunction

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic applyCycle(input logic v, input tagType t, input dataType d,
                              input laneMaskType m, input logic sf, input laneSelType off,
                              input logic dn, input logic er, input tagMapType clr);
        expectType e;
        @(negedge CLK);
        valid = v;
        tag = t;
        data = d;
        dataEn = m;
        startFlag = sf;
        startOffset = off;
        done = dn;
        err = er;
        tagClear = clr;
        clearModelTags(clr);
        e = '0;
        if (v) begin
            e = predictBeat(t, d, m, sf, off, dn, er);
            beatsSent++;
        end
        // Sampled on the next rising edge
        expTable[edgeCount + 1] = e;
    endtask

    task automatic sendBeat(input tagType t, input laneMaskType m, input logic dn,
                            input logic er);
        applyCycle(1'b1, t, randData(), m, 1'b0, '0, dn, er, '0);
    endtask

    task automatic sendStartBeat(input tagType t, input laneMaskType m, input laneSelType off);
        applyCycle(1'b1, t, randData(), m, 1'b1, off, 1'b0, 1'b0, '0);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) applyCycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic pulseClear(input tagMapType clr);
        applyCycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0, clr);
    endtask

    // --------------------------------------------------
    // Compare
    // --------------------------------------------------
    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compareOutputs(input expectType e);
        checkValue("pktValid", 128'(pktValid), 128'(e.valid));
        checkValue("storedEn", 128'(storedEn), 128'(e.en));
        checkValue("tagFinish", 128'(tagFinish), 128'(e.finish));
        if (pktValid) begin
            beatsSeen++;
        end
        if (e.valid) begin
            checkValue("pktTag", 128'(pktTag), 128'(e.tag));
            checkValue("pktWords", 128'(pktWords), 128'(e.words));
            checkValue("pktWordsLte1", 128'(pktWordsLte1), 128'(e.lte1));
            checkValue("pktWordsLte2", 128'(pktWordsLte2), 128'(e.lte2));
            checkValue("pktDone", 128'(pktDone), 128'(e.done));
            checkValue("pktErr", 128'(pktErr), 128'(e.err));
            checkValue("storedData", storedData, e.data);
            for (int l = 0; l < `RQ_LANES; l++) begin
                checkValue($sformatf("storedAddr[%0d]", l), 128'(storedAddr[l]),
                           128'(e.addr[l]));
            end
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge CLK) begin
        if (checkOn && edgeCount >= `RQ_PIPE_DEPTH) begin
            compareOutputs(expTable[edgeCount - `RQ_PIPE_DEPTH]);
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic runForwarding();
        // Back to back on one tag
        sendBeat(5'd5, 4'b0011, 1'b0, 1'b0);
        sendBeat(5'd5, 4'b0111, 1'b0, 1'b0);
        sendBeat(5'd5, 4'b0001, 1'b0, 1'b0);
        sendBeat(5'd5, 4'b1111, 1'b0, 1'b0);
        idleCycles(1);
        // One beat or one idle cycle between beats of tag 7
        sendBeat(5'd7, 4'b0111, 1'b0, 1'b0);
        sendBeat(5'd8, 4'b0001, 1'b0, 1'b0);
        sendBeat(5'd7, 4'b0011, 1'b0, 1'b0);
        idleCycles(1);
        sendBeat(5'd7, 4'b0111, 1'b0, 1'b0);
        sendBeat(5'd8, 4'b0011, 1'b0, 1'b0);
        sendBeat(5'd8, 4'b1111, 1'b0, 1'b0);
        sendBeat(5'd7, 4'b1111, 1'b0, 1'b0);
        idleCycles(1);
    endtask

    task automatic runStartOffset();
        sendStartBeat(5'd9, 4'b1110, 2'd1);
        sendBeat(5'd9, 4'b1111, 1'b0, 1'b0);
        sendBeat(5'd9, 4'b0011, 1'b0, 1'b0);
        sendStartBeat(5'd10, 4'b1000, 2'd3);
        sendBeat(5'd10, 4'b0111, 1'b0, 1'b0);
        idleCycles(1);
        sendBeat(5'd10, 4'b1111, 1'b0, 1'b0);
        sendStartBeat(5'd11, 4'b1100, 2'd2);
        sendBeat(5'd11, 4'b0001, 1'b0, 1'b0);
        sendBeat(5'd11, 4'b1111, 1'b0, 1'b0);
        idleCycles(1);
    endtask

    task automatic runRandom();
        logic [31:0] r;
        // Tags 16 to 31, contiguous masks of 1 to 4 words
        for (int b = 0; b < RANDOM_BEATS; b++) begin
            r = randWord();
            if (r[25:23] != 3'd0) begin
                sendBeat(tagType'(16 + int'(r[19:16])),
                         laneMaskType'(4'b1111 >> (2'd3 - r[21:20])),
                         r[29:26] == 4'd0, r[31:28] == 4'hf);
            end else begin
                idleCycles(1);
            end
        end
    endtask

    task automatic runFinishClear();
        sendBeat(5'd12, 4'b1111, 1'b0, 1'b0);
        sendBeat(5'd12, 4'b0011, 1'b1, 1'b0);
        sendBeat(5'd13, 4'b0111, 1'b0, 1'b1);
        sendBeat(5'd14, 4'b0001, 1'b1, 1'b1);
        // Nothing of tags 12 and 13 in flight when cleared
        idleCycles(10);
        pulseClear((tagMapType'(1) << 12) | (tagMapType'(1) << 13));
        idleCycles(2);
        sendBeat(5'd12, 4'b0001, 1'b0, 1'b0);
        sendBeat(5'd12, 4'b1111, 1'b0, 1'b0);
        sendBeat(5'd13, 4'b1111, 1'b1, 1'b0);
    endtask

    initial begin
        RST = 1'b1;
        valid = 1'b0;
        data = '0;
        dataEn = '0;
        startFlag = 1'b0;
        startOffset = '0;
        done = 1'b0;
        err = 1'b0;
        tag = '0;
        tagClear = '0;
        foreach (expTable[i]) expTable[i] = '0;
        clearModelTags('1);

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        checkOn = 1'b1;

        // Fresh tag, one full beat
        sendBeat(5'd3, 4'b1111, 1'b0, 1'b0);
        idleCycles(1);
        runForwarding();
        runStartOffset();
        runRandom();
        runFinishClear();
        // Drain the pipeline
        idleCycles(`RQ_PIPE_DEPTH + 2);
        @(negedge CLK);

        assert (beatsSeen == beatsSent) else begin
            errorCount++;
            $display("Beat count mismatch: %0d beats sent but %0d came out",
                     beatsSent, beatsSeen);
        end
        $display("Checks: %0d, errors: %0d, beats: %0d", checkCount, errorCount, beatsSent);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/reorderQueuePkg.sv
src/beatIf.sv
src/wordCounter.sv
src/laneSlot.sv
src/payloadAligner.sv
src/reorderQueueInput.sv
verification/reorderQueueInputTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = reorderQueueInputTb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
